// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wall -f vlog.f --top-module rv3_core_tb -o Vrv3_core_tb
	./obj_dir/Vrv3_core_tb | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== dv/rv3_core_chk.sv ====
// Bound checker for AXI request stability and hazard control rules of the core
module rv3_core_chk (
    input logic        clk,
    input logic        rst,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        if_ex_flush,
    input logic        if_ex_stall,
    input logic [31:0] insn_e,
    input logic [31:0] pc_e,
    input logic        valid_e
);
    timeunit 1ns;
    timeprecision 100ps;

    // Requests hold until accepted
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    // Stalled fetch/execute register keeps word, PC and valid bit
    if_ex_hold: assert property (@(posedge clk) disable iff (rst)
        if_ex_stall |=> $stable(insn_e) && $stable(pc_e) && $stable(valid_e))
        else $error("fetch/execute register changed during a stall");

    if_ex_bubble: assert property (@(posedge clk) disable iff (rst)
        if_ex_flush && !if_ex_stall |=> !valid_e)
        else $error("fetch/execute flush did not insert a bubble");

    // Quiet bus right after reset
    quiet_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> !awvalid && !wvalid && !arvalid)
        else $error("AXI valid high in the first cycle after reset");

endmodule

bind rv3_core_top rv3_core_chk rv3_core_chk_inst (.*);

// ==== dv/rv3_core_tb.sv ====
// Testbench for the RV32I subset core with an instruction ROM and an AXI4-Lite memory model
module rv3_core_tb import rv3_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_ALU = 0, K_LOAD_USE = 1, K_BR_TAKEN = 2, K_BR_NOT = 3, K_JAL = 4;
    localparam int NROWS = 12;
    localparam logic [11:0] RES_OFS = 12'h040;  // Result word address
    localparam logic [11:0] TMP_OFS = 12'h020;  // Scratch word for load-use

    typedef struct packed {
        logic [2:0]  kind;
        alu_op_t     op;
        logic [11:0] a;
        logic [11:0] b;
        word_t       exp;
    } row_t;

    logic       clk, rst, i_req, i_ready, halted;
    word_t      i_addr, i_rdata;
    word_t      awaddr, wdata, araddr, rdata;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;

    word_t       rom [64];
    word_t       mem [64];
    row_t        rows [NROWS];
    logic [31:0] rng;
    int          errors, fails;
    // Slave-side state
    logic        hs_aw, hs_w, hs_b, hs_ar, hs_r;
    word_t       awaddr_s, wdata_s, araddr_s, st_addr, st_data, ld_addr, last_addr;
    logic [3:0]  wstrb_s, st_strb;
    logic        aw_have, w_have, ar_have;
    int          aw_dly, w_dly, b_dly, ar_dly, r_dly, i_wait;

    rv3_core_top #(.RESET_PC(32'h0)) rv3_core_top_inst (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    // Instruction encoders built on the format union
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        insn_u u;
        u.r.funct7 = f7;
        u.r.rs2    = rs2;
        u.r.rs1    = rs1;
        u.r.funct3 = f3;
        u.r.rd     = rd;
        u.r.opcode = OP;
        return u;
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_t opc);
        insn_u u;
        u.i.imm    = imm;
        u.i.rs1    = rs1;
        u.i.funct3 = f3;
        u.i.rd     = rd;
        u.i.opcode = opc;
        return u;
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        insn_u u;
        u.s.imm_hi = imm[11:5];
        u.s.rs2    = rs2;
        u.s.rs1    = rs1;
        u.s.funct3 = F3_WORD;
        u.s.imm_lo = imm[4:0];
        u.s.opcode = STORE;
        return u;
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [12:0] ofs);
        insn_u u;
        u.b.imm12   = ofs[12];
        u.b.imm10_5 = ofs[10:5];
        u.b.rs2     = rs2;
        u.b.rs1     = rs1;
        u.b.funct3  = f3;
        u.b.imm4_1  = ofs[4:1];
        u.b.imm11   = ofs[11];
        u.b.opcode  = BRANCH;
        return u;
    endfunction

    function automatic word_t enc_j(reg_idx_t rd, logic [20:0] ofs);
        insn_u u;
        u.j.imm20    = ofs[20];
        u.j.imm10_1  = ofs[10:1];
        u.j.imm11    = ofs[11];
        u.j.imm19_12 = ofs[19:12];
        u.j.rd       = rd;
        u.j.opcode   = JAL;
        return u;
    endfunction

    function automatic string kind_name(input logic [2:0] k);
        case (k)
            K_ALU:      return "alu";
            K_LOAD_USE: return "load-use";
            K_BR_TAKEN: return "beq taken";
            K_BR_NOT:   return "bne not taken";
            default:    return "jal";
        endcase
    endfunction

    // Program for one row with EBREAK in the rest of the ROM
    task automatic load_program(input row_t r);
        word_t ebreak_w;
        ebreak_w = enc_i(EBREAK_IMM, 5'd0, 3'd0, 5'd0, SYSTEM);
        for (int k = 0; k < 64; k++) rom[k] = ebreak_w;
        rom[0] = enc_i(r.a, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM);  // x1 = a
        rom[1] = enc_i(r.b, 5'd0, F3_ADD_SUB, 5'd2, OP_IMM);  // x2 = b
        case (r.kind)
            K_ALU: begin
                case (r.op)
                    ALU_SUB: rom[2] = enc_r(7'h20, 5'd2, 5'd1, F3_ADD_SUB, 5'd3);
                    ALU_AND: rom[2] = enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd3);
                    ALU_OR:  rom[2] = enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd3);
                    default: rom[2] = enc_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3);
                endcase
                rom[3] = enc_s(RES_OFS, 5'd3, 5'd0);
            end
            K_LOAD_USE: begin
                rom[2] = enc_s(TMP_OFS, 5'd1, 5'd0);
                rom[3] = enc_i(TMP_OFS, 5'd0, F3_WORD, 5'd4, LOAD);
                rom[4] = enc_r(7'h00, 5'd2, 5'd4, F3_ADD_SUB, 5'd3); // Uses the load at once
                rom[5] = enc_s(RES_OFS, 5'd3, 5'd0);
            end
            K_BR_TAKEN, K_BR_NOT: begin
                rom[2] = enc_i(12'h011, 5'd0, F3_ADD_SUB, 5'd3, OP_IMM);
                rom[3] = enc_b(r.kind == K_BR_TAKEN ? F3_BEQ : F3_BNE, 5'd1, 5'd2, 13'd8);
                rom[4] = enc_i(12'h022, 5'd0, F3_ADD_SUB, 5'd3, OP_IMM); // Fall-through path
                rom[5] = enc_s(RES_OFS, 5'd3, 5'd0);
            end
            default: begin
                rom[2] = enc_j(5'd5, 21'd8);                              // Link is 12
                rom[3] = enc_i(12'h033, 5'd0, F3_ADD_SUB, 5'd5, OP_IMM); // Skipped
                rom[4] = enc_r(7'h00, 5'd1, 5'd5, F3_ADD_SUB, 5'd3);
                rom[5] = enc_s(RES_OFS, 5'd3, 5'd0);
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Handshakes seen mid-cycle complete at the next rising edge
    always @(negedge clk) begin
        hs_aw    = awvalid && awready;
        hs_w     = wvalid && wready;
        hs_b     = bvalid && bready;
        hs_ar    = arvalid && arready;
        hs_r     = rvalid && rready;
        awaddr_s = awaddr;
        wdata_s  = wdata;
        wstrb_s  = wstrb;
        araddr_s = araddr;
    end

    // Instruction ROM, 0 to 2 cycles per new address
    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (i_addr != last_addr) begin
                last_addr = i_addr;
                i_wait    = rand_below(3);
            end else if (i_wait > 0) begin
                i_wait--;
            end
            i_ready = i_req && i_wait == 0;
            i_rdata = rom[i_addr[7:2]];
        end
    end

    // AXI4-Lite slave, 0 to 3 cycles on each channel
    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (rst) begin
                {awready, wready, bvalid, arready, rvalid} = '0;
                {aw_have, w_have, ar_have} = '0;
                aw_dly = rand_below(4);
                w_dly  = rand_below(4);
                b_dly  = rand_below(4);
                ar_dly = rand_below(4);
                r_dly  = rand_below(4);
            end else begin
                if (hs_aw) begin
                    aw_have = 1'b1;
                    st_addr = awaddr_s;
                    awready = 1'b0;
                    aw_dly  = rand_below(4);
                end else if (awvalid && !aw_have && !awready) begin
                    if (aw_dly == 0) awready = 1'b1;
                    else aw_dly--;
                end
                if (hs_w) begin
                    w_have  = 1'b1;
                    st_data = wdata_s;
                    st_strb = wstrb_s;
                    wready  = 1'b0;
                    w_dly   = rand_below(4);
                end else if (wvalid && !w_have && !wready) begin
                    if (w_dly == 0) wready = 1'b1;
                    else w_dly--;
                end
                if (hs_b) begin
                    bvalid = 1'b0;
                end else if (aw_have && w_have && !bvalid) begin
                    if (b_dly == 0) begin
                        // Write lands with the response, only on strobed lanes
                        for (int lane = 0; lane < 4; lane++) begin
                            if (st_strb[lane]) begin
                                mem[st_addr[7:2]][8*lane +: 8] = st_data[8*lane +: 8];
                            end
                        end
                        bvalid  = 1'b1;
                        aw_have = 1'b0;
                        w_have  = 1'b0;
                        b_dly   = rand_below(4);
                    end else begin
                        b_dly--;
                    end
                end
                if (hs_ar) begin
                    ar_have = 1'b1;
                    ld_addr = araddr_s;
                    arready = 1'b0;
                    ar_dly  = rand_below(4);
                end else if (arvalid && !ar_have && !arready) begin
                    if (ar_dly == 0) arready = 1'b1;
                    else ar_dly--;
                end
                if (hs_r) begin
                    rvalid = 1'b0;
                end else if (ar_have && !rvalid) begin
                    if (r_dly == 0) begin
                        rdata   = mem[ld_addr[7:2]];
                        rvalid  = 1'b1;
                        ar_have = 1'b0;
                        r_dly   = rand_below(4);
                    end else begin
                        r_dly--;
                    end
                end
            end
        end
    end

    initial begin
        logic  done;
        word_t got;
        rng = 32'h6b9a7b20;
        rst = 1'b1;
        {i_ready, awready, wready, bvalid, arready, rvalid} = '0;
        i_rdata   = '0;
        rdata     = '0;
        bresp     = 2'b00;   // OKAY only
        rresp     = 2'b00;
        last_addr = 32'hffff_ffff;
        errors    = 0;
        fails     = 0;
        // kind, op, a, b, expected word at the result address
        rows[0]  = '{K_ALU, ALU_ADD, 12'h123, 12'h045, 32'h0000_0168};
        rows[1]  = '{K_ALU, ALU_SUB, 12'h123, 12'h045, 32'h0000_00de};
        rows[2]  = '{K_ALU, ALU_AND, 12'h123, 12'h045, 32'h0000_0001};
        rows[3]  = '{K_ALU, ALU_OR,  12'h123, 12'h045, 32'h0000_0167};
        rows[4]  = '{K_ALU, ALU_ADD, 12'hffb, 12'h003, 32'hffff_fffe};  // -5 and 3
        rows[5]  = '{K_ALU, ALU_SUB, 12'hffb, 12'h003, 32'hffff_fff8};
        rows[6]  = '{K_ALU, ALU_AND, 12'hffb, 12'h003, 32'h0000_0003};
        rows[7]  = '{K_ALU, ALU_OR,  12'hffb, 12'h003, 32'hffff_fffb};
        rows[8]  = '{K_LOAD_USE, ALU_ADD, 12'h7ff, 12'h001, 32'h0000_0800};
        rows[9]  = '{K_BR_TAKEN, ALU_ADD, 12'h05c, 12'h05c, 32'h0000_0011};
        rows[10] = '{K_BR_NOT,   ALU_ADD, 12'h05c, 12'h05c, 32'h0000_0022};
        rows[11] = '{K_JAL,      ALU_ADD, 12'h100, 12'h000, 32'h0000_010c}; // Link 12 plus a
        for (int n = 0; n < NROWS; n++) begin
            errors = 0;
            @(posedge clk);
            #10;
            rst = 1'b1;
            load_program(rows[n]);
            for (int k = 0; k < 64; k++) mem[k] = 32'hd000_0000 | (k * 32'h0001_0101);
            repeat (4) @(posedge clk);
            #10;
            rst  = 1'b0;
            done = 1'b0;
            for (int cyc = 0; cyc < 500 && !done; cyc++) begin  // Halt timeout
                @(posedge clk);
                #40;
                done = halted;
            end
            assert (done) else begin
                $display("row %0d: halted did not rise within 500 cycles", n);
                errors++;
            end
            got = mem[RES_OFS[7:2]];
            assert (got == rows[n].exp) else begin
                $display("[ERROR] row %0d mem[0x%02h] got 0x%08h expected 0x%08h",
                         n, RES_OFS, got, rows[n].exp);
                errors++;
            end
            $display("row %0d %s a=0x%03h b=0x%03h: %s", n, kind_name(rows[n].kind),
                     rows[n].a, rows[n].b, errors == 0 ? "ok" : "FAIL");
            if (errors != 0) fails++;
        end
        $display("rows run %0d, rows failed %0d", NROWS, fails);
        if (fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/execute_stage.sv ====
// Execute stage that decodes, forwards, computes and resolves branches
module execute_stage import rv3_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    insn_e,
    input  word_t    pc_e,
    input  logic     valid_e,
    input  word_t    rd1,
    input  word_t    rd2,
    output reg_idx_t ra1,
    output reg_idx_t ra2,
    output reg_idx_t rs1_e,
    output reg_idx_t rs2_e,
    output logic     uses_rs2_e,
    output logic     jump_e,
    output logic     branch_taken_e,
    output logic     ebreak_e,
    output word_t    target_e,
    input  reg_idx_t fwd_rd_m,
    input  word_t    fwd_val_m,
    input  logic     fwd_we_m,
    input  logic     ex_mem_stall,
    input  logic     ex_mem_flush,
    output reg_idx_t rd_m,
    output logic     reg_write_m,
    output logic     load_m,
    output logic     store_m,
    output logic     ebreak_m,
    output word_t    alu_m,
    output word_t    store_data_m
);

    insn_u   insn;
    opcode_t opc;
    logic    is_op, is_imm, is_load, is_store, is_branch, is_jal;
    logic    reg_write_e;
    word_t   imm_i, imm_s, imm_b, imm_j;
    word_t   op1, op2, op_b;
    alu_op_t alu_op;
    word_t   alu_res;

    assign insn = insn_e;
    assign opc  = insn.r.opcode;

    assign rs1_e = insn.r.rs1;
    assign rs2_e = insn.r.rs2;
    assign ra1   = rs1_e;
    assign ra2   = rs2_e;

    // Decode, qualified by the valid bit so bubbles do nothing
    assign is_op     = valid_e && opc == OP;
    assign is_imm    = valid_e && opc == OP_IMM;
    assign is_load   = valid_e && opc == LOAD && insn.i.funct3 == F3_WORD;
    assign is_store  = valid_e && opc == STORE && insn.s.funct3 == F3_WORD;
    assign is_branch = valid_e && opc == BRANCH;
    assign is_jal    = valid_e && opc == JAL;
    assign ebreak_e  = valid_e && opc == SYSTEM && insn.i.imm == EBREAK_IMM;
    assign uses_rs2_e = opc == OP || opc == STORE || opc == BRANCH;
    assign reg_write_e = is_op | is_imm | is_load | is_jal;

    assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
    assign imm_s = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
    assign imm_b = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
                    insn.b.imm10_5, insn.b.imm4_1, 1'b0};
    assign imm_j = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12,
                    insn.j.imm11, insn.j.imm10_1, 1'b0};

    // Bypass from the memory stage on register match
    assign op1 = (fwd_we_m && fwd_rd_m != '0 && fwd_rd_m == rs1_e) ? fwd_val_m : rd1;
    assign op2 = (fwd_we_m && fwd_rd_m != '0 && fwd_rd_m == rs2_e) ? fwd_val_m : rd2;
    assign op_b = is_op ? op2 : (opc == STORE) ? imm_s : imm_i;

    always_comb begin
        alu_op = ALU_ADD;   // Loads, stores, ADDI
        if (is_op || is_imm) begin
            case (insn.r.funct3)
                F3_ADD_SUB: alu_op = (is_op && insn.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                F3_AND:     alu_op = ALU_AND;
                F3_OR:      alu_op = ALU_OR;
                default:    alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = op1 - op_b;
            ALU_AND: alu_res = op1 & op_b;
            ALU_OR:  alu_res = op1 | op_b;
            default: alu_res = op1 + op_b;
        endcase
    end

    // Branch compare on forwarded operands
    assign branch_taken_e = is_branch &&
                            ((insn.b.funct3 == F3_BEQ && op1 == op2) ||
                             (insn.b.funct3 == F3_BNE && op1 != op2));
    assign jump_e   = is_jal;
    assign target_e = pc_e + (is_jal ? imm_j : imm_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m <= 1'b0;
            load_m      <= 1'b0;
            store_m     <= 1'b0;
            ebreak_m    <= 1'b0;
        end else if (!ex_mem_stall) begin
            reg_write_m <= reg_write_e & ~ex_mem_flush; // Flush inserts a bubble
            load_m      <= is_load & ~ex_mem_flush;
            store_m     <= is_store & ~ex_mem_flush;
            ebreak_m    <= ebreak_e & ~ex_mem_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_mem_stall) begin
            rd_m         <= insn.r.rd;
            alu_m        <= is_jal ? pc_e + 32'd4 : alu_res; // Link address for JAL
            store_data_m <= op2;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
// Fetch stage holding the PC and the fetch/execute pipeline register
module fetch_stage import rv3_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  pc_en,
    input  logic  npc_sel,
    input  word_t target_e,
    input  logic  if_ex_stall,
    input  logic  if_ex_flush,
    input  logic  i_ready,
    input  word_t i_rdata,
    output logic  i_req,
    output word_t i_addr,
    output logic  i_busy,
    output word_t insn_e,
    output word_t pc_e,
    output logic  valid_e
);

    word_t pc;
    word_t pc_next;

    assign pc_next = npc_sel ? target_e : pc + 32'd4; // Predict not-taken
    assign i_req   = 1'b1;              // Request every cycle and drop unused words
    assign i_addr  = pc;
    assign i_busy  = i_req & ~i_ready;  // Word for this PC not back yet

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    // Bubble on flush or when the port had no word
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_e <= 1'b0;
        end else if (!if_ex_stall) begin
            valid_e <= ~if_ex_flush & i_req & i_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (!if_ex_stall) begin
            insn_e <= i_rdata;
            pc_e   <= pc;   // PC travels with its word
        end
    end

endmodule

// ==== verilog/hazard_unit.sv ====
// Hazard unit deciding stall, flush and PC redirect for the three stages
module hazard_unit import rv3_pkg::*; (
    input  logic     i_busy,
    input  reg_idx_t rs1_e,
    input  reg_idx_t rs2_e,
    input  logic     uses_rs2_e,
    input  logic     jump_e,
    input  logic     branch_taken_e,
    input  logic     ebreak_e,
    input  reg_idx_t rd_m,
    input  logic     reg_write_m,
    input  logic     load_m,
    input  logic     d_busy_m,
    input  logic     halted,
    output logic     pc_en,
    output logic     npc_sel,
    output logic     if_ex_stall,
    output logic     if_ex_flush,
    output logic     ex_mem_stall,
    output logic     ex_mem_flush
);

    logic rs1_match;
    logic rs2_match;
    logic load_use;
    logic control;

    assign rs1_match = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match = uses_rs2_e && (rs2_e == rd_m) && (rd_m != '0);
    assign load_use  = load_m && reg_write_m && (rs1_match || rs2_match); // Load data not forwardable

    // Redirect only with valid operands and a live core
    assign control = (jump_e || branch_taken_e) && !load_use && !halted;
    assign npc_sel = control;

    // Later-stage stall implies earlier-stage stall
    assign ex_mem_stall = d_busy_m     // Slow data slave freezes all
                       || halted;
    assign if_ex_stall  = ex_mem_stall
                       || load_use;     // Hold consumer until the load writes back

    // Flush loses to a stall of the same register
    assign if_ex_flush  = (control      // Drop the not-taken path word
                       || i_busy)       // No word this cycle, insert bubble
                       && !if_ex_stall;

    // Bubble behind a load-use stall; the resolving branch or jump still retires
    assign ex_mem_flush = if_ex_stall && !ex_mem_stall;

    // PC moves on a redirect or when fetch hands off a word
    assign pc_en = control
                || !(ex_mem_stall || if_ex_stall || i_busy
                     || ebreak_e);      // Stop fetching past EBREAK

endmodule

// ==== verilog/mem_stage.sv ====
// Memory stage with an AXI4-Lite master for loads and stores and the writeback port
module mem_stage import rv3_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_idx_t   rd_m,
    input  logic       reg_write_m,
    input  logic       load_m,
    input  logic       store_m,
    input  logic       ebreak_m,
    input  word_t      alu_m,
    input  word_t      store_data_m,
    output word_t      awaddr,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output logic [3:0] wstrb,
    output logic       wvalid,
    input  logic       wready,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready,
    output word_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    input  logic       rvalid,
    output logic       rready,
    output logic       d_busy_m,
    output logic       we,
    output reg_idx_t   wa,
    output word_t      wd,
    output word_t      fwd_val_m,
    output logic       halted
);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_RESP} state_t;

    state_t state, state_next;
    logic   aw_done, w_done, ar_done;   // Channel handshakes already taken
    logic   halt_q;
    logic   issue;
    logic   addr_ok;
    logic   resp_hs;
    logic   bus_err;

    assign issue   = state != ST_RESP && !halt_q;
    assign awvalid = store_m & issue & ~aw_done;    // AW and W rise together
    assign wvalid  = store_m & issue & ~w_done;
    assign arvalid = load_m & issue & ~ar_done;
    assign awaddr  = alu_m;
    assign araddr  = alu_m;
    assign wdata   = store_data_m;
    assign wstrb   = 4'b1111;       // Word accesses only
    assign bready  = store_m;
    assign rready  = load_m;

    // All request channels complete by the end of this cycle
    assign addr_ok = load_m ? (ar_done | (arvalid & arready))
                            : ((aw_done | (awvalid & awready)) & (w_done | (wvalid & wready)));
    assign resp_hs = state == ST_RESP && (load_m ? rvalid : bvalid);
    assign bus_err = load_m ? rresp[1] : bresp[1];  // SLVERR or DECERR
    assign d_busy_m = (load_m | store_m) & ~resp_hs;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_ADDR: begin
                if ((load_m || store_m) && !halt_q) begin
                    state_next = addr_ok ? ST_RESP : ST_ADDR;
                end
            end
            ST_RESP: if (resp_hs) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
            halt_q  <= 1'b0;
        end else begin
            state   <= state_next;
            aw_done <= state_next == ST_ADDR && (aw_done || (awvalid && awready));
            w_done  <= state_next == ST_ADDR && (w_done || (wvalid && wready));
            ar_done <= state_next == ST_ADDR && (ar_done || (arvalid && arready));
            halt_q  <= halt_q | ebreak_m | (resp_hs & bus_err); // Stays set after EBREAK or bus error
        end
    end

    // ALU results retire in one cycle, loads on the read response
    assign we        = reg_write_m & ~halt_q & (~load_m | resp_hs);
    assign wa        = rd_m;
    assign wd        = load_m ? rdata : alu_m;
    assign fwd_val_m = alu_m;
    assign halted    = halt_q | ebreak_m;   // Freezes the pipe from EBREAK's memory cycle

endmodule

// ==== verilog/reg_file.sv ====
// Register file with 32 words, two read ports and one write port
module reg_file import rv3_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && wa != '0) begin   // x0 stays zero
            regs[wa] <= wd;
        end
    end

    // Write-through so writeback and read in one cycle agree
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== verilog/rv3_core_top.sv ====
// Top of the three-stage RV32I subset core with instruction and AXI4-Lite data ports
module rv3_core_top import rv3_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       rst,
    output logic       i_req,
    output word_t      i_addr,
    input  word_t      i_rdata,
    input  logic       i_ready,
    output word_t      awaddr,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output logic [3:0] wstrb,
    output logic       wvalid,
    input  logic       wready,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready,
    output word_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    input  logic       rvalid,
    output logic       rready,
    output logic       halted
);

    // Hazard control
    logic     pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic     i_busy;
    // Fetch/execute register
    word_t    insn_e, pc_e;
    logic     valid_e;
    // Execute outputs
    reg_idx_t ra1, ra2, rs1_e, rs2_e;
    word_t    rd1, rd2, target_e;
    logic     uses_rs2_e, jump_e, branch_taken_e, ebreak_e;
    // Execute/memory register
    reg_idx_t rd_m;
    logic     reg_write_m, load_m, store_m, ebreak_m;
    word_t    alu_m, store_data_m;
    // Memory stage and writeback
    logic     d_busy_m, we;
    reg_idx_t wa;
    word_t    wd, fwd_val_m;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
        .clk, .rst, .pc_en, .npc_sel, .target_e, .if_ex_stall, .if_ex_flush,
        .i_ready, .i_rdata, .i_req, .i_addr, .i_busy, .insn_e, .pc_e, .valid_e
    );

    reg_file reg_file_inst (
        .clk, .rst, .ra1, .ra2, .rd1, .rd2, .we, .wa, .wd
    );

    execute_stage execute_stage_inst (
        .clk, .rst, .insn_e, .pc_e, .valid_e, .rd1, .rd2, .ra1, .ra2,
        .rs1_e, .rs2_e, .uses_rs2_e, .jump_e, .branch_taken_e, .ebreak_e, .target_e,
        .fwd_rd_m(rd_m), .fwd_val_m, .fwd_we_m(reg_write_m),   // Bypass from memory stage
        .ex_mem_stall, .ex_mem_flush,
        .rd_m, .reg_write_m, .load_m, .store_m, .ebreak_m, .alu_m, .store_data_m
    );

    mem_stage mem_stage_inst (
        .clk, .rst, .rd_m, .reg_write_m, .load_m, .store_m, .ebreak_m, .alu_m, .store_data_m,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .d_busy_m, .we, .wa, .wd, .fwd_val_m, .halted
    );

    hazard_unit hazard_unit_inst (
        .i_busy, .rs1_e, .rs2_e, .uses_rs2_e, .jump_e, .branch_taken_e, .ebreak_e,
        .rd_m, .reg_write_m, .load_m, .d_busy_m, .halted,
        .pc_en, .npc_sel, .if_ex_stall, .if_ex_flush, .ex_mem_stall, .ex_mem_flush
    );

endmodule

// ==== verilog/rv3_pkg.sv ====
// Shared types and encodings for the three-stage RV32I subset core
package rv3_pkg;

    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  reg_idx_t; // Architectural register index

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // Major opcodes of the supported instructions
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

    localparam logic [2:0]  F3_ADD_SUB = 3'b000; // Also ADDI
    localparam logic [2:0]  F3_OR      = 3'b110;
    localparam logic [2:0]  F3_AND     = 3'b111;
    localparam logic [2:0]  F3_BEQ     = 3'b000;
    localparam logic [2:0]  F3_BNE     = 3'b001;
    localparam logic [2:0]  F3_WORD    = 3'b010; // LW and SW width
    localparam logic [11:0] EBREAK_IMM = 12'h001;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // imm[4:0]
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word, viewed in each encoding format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } insn_u;

endpackage

// ==== vlog.f ====
verilog/rv3_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/rv3_core_top.sv
dv/rv3_core_chk.sv
dv/rv3_core_tb.sv
